/* build.f */
source/display_pkg.sv
source/display_timing.sv
source/fb_ram.sv
source/fb_arbiter.sv
source/scanout.sv
source/display_top.sv
sim/display_properties.sv
sim/display_checker.sv
sim/display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module display_tb \
    -o display_sim || exit 1
out=$(./obj_dir/display_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

/* sim/display_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches the DUT ports, keeps a model of written pixels and
// checks reset, host read-back, arbitration, timing and colour.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module display_checker import display_pkg::*; (
    input  logic                   clk_pix,
    input  logic                   rst_pix,
    input  wb_req_t                wb_req,
    input  wb_rsp_t                wb_rsp,
    input  display_out_t           video,
    input  logic [color_width-1:0] exp_color,  // expected read data
    input  logic                   host_done,  // all records acked
    output logic                   frame_done,
    output int                     tests_passed,
    output int                     tests_failed
);

    typedef enum int {reset_state, host_readback, ack_pulse, arbitration,
                      line_timing, frame_timing, pixel_output} test_e;

    localparam int line_cycles  = h_res + h_fp + h_sync + h_bp;  // 800
    localparam int frame_cycles = line_cycles * (v_res + v_fp + v_sync + v_bp);

    logic [color_width-1:0] shadow [int];  // last colour written per address
    int   errs [7] = '{default: 0};
    logic rst_d = 1'b0;
    logic ack_d = 1'b0;
    logic stb_d = 1'b0;
    logic host_seen = 1'b0;  // host tests reported
    logic checking = 1'b0;   // inside the checked frame
    logic done_q = 1'b0;
    int   passed_n = 0;
    int   failed_n = 0;
    int   x = h_sta;         // position of the pixel on video now
    int   y = v_sta;
    int   starts = 0;
    int   acks = 0;
    int   line_len, hs_low, de_cnt, frame_len, vs_low, de_lines, pix_hits;

    assign frame_done   = done_q;
    assign tests_passed = passed_n;
    assign tests_failed = failed_n;

    task automatic value_error(input test_e t, input string what, input int expv,
                               input int actv, input bit as_hex);
        if (as_hex) begin
            $display("Fail %s %s expected %0h actual %0h", t.name(), what, expv, actv);
        end else begin
            $display("Fail %s %s expected %0d actual %0d", t.name(), what, expv, actv);
        end
        errs[t]++;
    endtask

    task automatic plain_error(input test_e t, input string msg);
        $display("%s: %s", t.name(), msg);
        errs[t]++;
    endtask

    task automatic report_test(input test_e t);
        if (errs[t] == 0) begin
            $display("test %s ok", t.name());
            passed_n++;
        end else begin
            $display("test %s failed with %0d errors", t.name(), errs[t]);
            failed_n++;
        end
    endtask

    always @(posedge clk_pix) begin
        int addr;
        if (rst_d) begin  // outputs show reset one edge after it is sampled
            if (!video.sync.hsync || !video.sync.vsync || video.sync.de || video.sync.frame
                    || video.sync.line || wb_rsp.ack) begin
                plain_error(reset_state, "sync, de, frame, line or ack not idle in reset");
            end
            if (video.color != '0) value_error(reset_state, "colour", 0, int'(video.color), 1);
            if (!rst_pix) report_test(reset_state);
        end
        // position rebuilt from the video pulses
        if (video.sync.frame) begin
            x = h_sta;
            y = v_sta;
        end else if (video.sync.line) begin
            x = h_sta;
            y++;
        end else begin
            x++;
        end
        if (!rst_pix) begin
            if (wb_req.cyc && wb_req.stb && (!stb_d || ack_d)) starts++;  // new access
            if (wb_rsp.ack) begin
                acks++;
                if (ack_d) plain_error(ack_pulse, "ack high two cycles in a row");
                if (wb_req.we) begin
                    shadow[int'(wb_req.adr)] = wb_req.dat_w;
                end else if (wb_rsp.dat_r !== exp_color) begin
                    value_error(host_readback, $sformatf("adr %0h", wb_req.adr),
                                int'(exp_color), int'(wb_rsp.dat_r), 1);
                end
            end
            // ack at c means the counted pixel at c+1 lies in blanking
            if (ack_d && x >= 0 && y >= 0) begin
                plain_error(arbitration, "ack while scanout owned memory");
            end
            if (host_done && !host_seen) begin
                if (acks != starts) begin
                    plain_error(arbitration, $sformatf("%0d accesses but %0d acks", starts, acks));
                end
                report_test(host_readback);
                report_test(ack_pulse);
                report_test(arbitration);
                host_seen = 1'b1;
            end
        end
        if (video.sync.line && checking) begin  // close previous line
            if (line_len != line_cycles) value_error(line_timing, "line cycles", line_cycles,
                                                     line_len, 0);
            if (hs_low != h_sync) value_error(line_timing, "hsync low", h_sync, hs_low, 0);
            if (de_cnt != 0 && de_cnt != h_res) value_error(line_timing, "de", h_res, de_cnt, 0);
            if (de_cnt == h_res) de_lines++;
            line_len = 0;
            hs_low   = 0;
            de_cnt   = 0;
        end
        if (video.sync.frame && checking) begin  // close the frame
            if (frame_len != frame_cycles) value_error(frame_timing, "frame cycles",
                                                       frame_cycles, frame_len, 0);
            if (vs_low != v_sync * line_cycles) value_error(frame_timing, "vsync low",
                                                            v_sync * line_cycles, vs_low, 0);
            if (de_lines != v_res) value_error(frame_timing, "de lines", v_res, de_lines, 0);
            if (pix_hits != 16 * shadow.num()) begin
                plain_error(pixel_output, "not every written block showed all 16 pixels");
            end
            report_test(line_timing);
            report_test(frame_timing);
            report_test(pixel_output);
            checking = 1'b0;
            done_q   = 1'b1;
        end else if (video.sync.frame && host_seen && !done_q) begin
            checking  = 1'b1;
            line_len  = 0;
            hs_low    = 0;
            de_cnt    = 0;
            frame_len = 0;
            vs_low    = 0;
            de_lines  = 0;
            pix_hits  = 0;
        end
        if (checking) begin
            line_len++;
            frame_len++;
            if (!video.sync.hsync) hs_low++;
            if (!video.sync.vsync) vs_low++;
            if (video.sync.de != (x >= 0 && y >= 0)) begin
                plain_error(line_timing, $sformatf("de wrong at x %0d y %0d", x, y));
            end
            if (video.sync.de && x >= 0 && y >= 0) begin
                de_cnt++;
                addr = (y / 4) * fb_width + x / 4;  // 4x4 screen block per word
                if (shadow.exists(addr)) begin
                    pix_hits++;
                    if (video.color !== shadow[addr]) begin
                        value_error(pixel_output, $sformatf("x %0d y %0d", x, y),
                                    int'(shadow[addr]), int'(video.color), 1);
                    end
                end
            end else if (video.color != '0) begin
                value_error(pixel_output, "blank colour", 0, int'(video.color), 1);
            end
        end
        rst_d = rst_pix;
        ack_d = wb_rsp.ack;
        stb_d = wb_req.cyc && wb_req.stb;
    end

endmodule

/* sim/display_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on reset state, ack and sync alignment, bound into
// display_top. Each flag latches a failed assertion.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module display_properties import display_pkg::*; (
    input logic          clk_pix,
    input logic          rst_pix,
    input wb_req_t       wb_req,
    input wb_rsp_t       wb_rsp,
    input display_out_t  video,
    input display_sync_t timing_sync  // timing output inside the top
);

    logic reset_bad = 1'b0;
    logic ack_bad   = 1'b0;
    logic req_bad   = 1'b0;
    logic align_bad = 1'b0;
    logic failed;

    assign failed = reset_bad || ack_bad || req_bad || align_bad;

    reset_idle: assert property (@(posedge clk_pix) rst_pix |=>
        video.sync.hsync && video.sync.vsync && !video.sync.de && !video.sync.frame
        && !wb_rsp.ack && video.color == '0)
        else begin
            $error("video or ack not idle after a reset edge");
            reset_bad = 1'b1;
        end

    ack_single: assert property (@(posedge clk_pix) disable iff (rst_pix)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack longer than one cycle");
            ack_bad = 1'b1;
        end

    ack_with_stb: assert property (@(posedge clk_pix) disable iff (rst_pix)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
        else begin
            $error("ack without cyc and stb");
            req_bad = 1'b1;
        end

    // video sync trails the timing generator by 3 cycles
    sync_aligned: assert property (@(posedge clk_pix) disable iff (rst_pix)
        video.sync == $past(timing_sync, 3))
        else begin
            $error("video sync not 3 cycles behind timing");
            align_bad = 1'b1;
        end

endmodule

bind display_top display_properties u_display_properties (
    .clk_pix     (clk_pix),
    .rst_pix     (rst_pix),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .video       (video),
    .timing_sync (timing_sync)
);

/* sim/display_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the framebuffer display. Plays the host records
// over Wishbone, then lets the checker watch one full frame.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module display_tb import display_pkg::*; ();

    localparam int num_tests    = 7;    // tests the checker reports
    localparam int max_records  = 64;
    localparam int frame_cycles = 800 * 525;

    logic                   clk_pix = 1'b0;
    logic                   rst_pix;
    wb_req_t                wb_req;
    wb_rsp_t                wb_rsp;
    display_out_t           video;
    logic [color_width-1:0] exp_color;  // read-back value from the data file
    logic                   host_done;
    logic                   frame_done;
    int                     tests_passed;
    int                     tests_failed;
    logic [15:0]            records [max_records * 3];  // kind, address, colour
    int                     num_records;
    int                     timeout_limit = 0;

    always #4 clk_pix = ~clk_pix;  // 8 ns period

    display_top u_display_top (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .video   (video)
    );

    display_checker u_display_checker (
        .clk_pix      (clk_pix),
        .rst_pix      (rst_pix),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .video        (video),
        .exp_color    (exp_color),
        .host_done    (host_done),
        .frame_done   (frame_done),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    // one classic access, entered 1 ns after a rising edge
    task automatic bus_access(input logic is_write, input logic [fb_addr_width-1:0] adr,
                              input logic [color_width-1:0] color);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = is_write;
        wb_req.adr   = adr;
        wb_req.dat_w = is_write ? color : '0;
        exp_color    = color;
        @(negedge clk_pix);
        while (!wb_rsp.ack) begin  // wait states while scanout owns memory
            @(negedge clk_pix);
        end
        @(posedge clk_pix);
        #1;
        wb_req    = '0;  // drop stb in the cycle after ack
        exp_color = '0;
    endtask

    // watchdog: 3 frames plus 1000 cycles per record
    initial begin
        int cycles;
        cycles = 0;
        wait (timeout_limit != 0);
        while (cycles < timeout_limit) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_pix   = 1'b1;
        wb_req    = '0;
        exp_color = '0;
        host_done = 1'b0;
        for (int i = 0; i < max_records * 3; i++) begin
            records[i] = 16'h0;  // kind 0 ends the list
        end
        $readmemh("sim/display_testdata.hex", records);
        num_records = 0;
        while (num_records < max_records && records[num_records * 3] != 16'h0) begin
            num_records++;
        end
        timeout_limit = 3 * frame_cycles + 1000 * num_records;
        repeat (4) @(posedge clk_pix);
        #1;
        rst_pix = 1'b0;
        while (!video.sync.de) begin  // first access lands in active video
            @(negedge clk_pix);
        end
        @(posedge clk_pix);
        #1;
        for (int i = 0; i < num_records; i++) begin
            bus_access(records[i * 3] == 16'h1, records[i * 3 + 1][fb_addr_width-1:0],
                       records[i * 3 + 2][color_width-1:0]);
        end
        host_done = 1'b1;
        while (!frame_done) begin
            @(negedge clk_pix);
        end
        $display("tests passed %0d, failed %0d, assertion flags %0d", tests_passed,
                 tests_failed, u_display_top.u_display_properties.failed);
        if (tests_failed == 0 && tests_passed == num_tests
                && !u_display_top.u_display_properties.failed) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sim/display_testdata.hex */
// columns: kind (1 write, 2 read-back, 0 end), framebuffer address, colour
// a read-back expects the colour last written to its address
1 0000 0f00
1 009f 00f0
1 00a0 000f
1 4aff 0fff
1 12c5 0a5a
1 2580 0123
1 12c5 0c3c
1 0001 0777
2 0000 0f00
2 009f 00f0
2 00a0 000f
2 4aff 0fff
2 12c5 0c3c
2 2580 0123
2 0001 0777
1 3e7d 0e1d
2 3e7d 0e1d
0 0000 0000

/* source/display_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared timing, framebuffer geometry and bus structs for the
// 640x480p60 framebuffer display. Import with display_pkg::*.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package display_pkg;

    localparam int coord_width = 16;  // signed screen coordinates

    // 640x480 at 60 Hz, 25.175 MHz nominal pixel clock
    localparam int h_res  = 640;
    localparam int v_res  = 480;
    localparam int h_fp   = 16;   // front porch
    localparam int h_sync = 96;
    localparam int h_bp   = 48;   // back porch
    localparam int v_fp   = 10;
    localparam int v_sync = 2;
    localparam int v_bp   = 33;
    localparam bit h_pol  = 1'b0;  // 0 means negative sync
    localparam bit v_pol  = 1'b0;

    localparam int h_sta  = 0 - h_fp - h_sync - h_bp;  // -160, first blanking column
    localparam int v_sta  = 0 - v_fp - v_sync - v_bp;  // -45, first blanking line
    localparam int hs_sta = h_sta + h_fp;  // hsync start
    localparam int hs_end = hs_sta + h_sync;
    localparam int vs_sta = v_sta + v_fp;  // vsync start
    localparam int vs_end = vs_sta + v_sync;
    localparam int ha_end = h_res - 1;  // last active pixel
    localparam int va_end = v_res - 1;  // last active line

    localparam int fb_width       = 160;
    localparam int fb_height      = 120;
    localparam int fb_scale_shift = 2;  // 4x4 screen pixels per stored pixel
    localparam int fb_depth       = fb_width * fb_height;  // 19200 words
    localparam int fb_addr_width  = 15;
    localparam int color_width    = 12;  // 4:4:4 rgb

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;     // data enable
        logic frame;  // first blanking pixel of frame
        logic line;   // first pixel of each line
    } display_sync_t;

    // idle sync state, used by reset of timing and delay stages
    localparam display_sync_t sync_idle = '{hsync: ~h_pol, vsync: ~v_pol,
                                            de: 1'b0, frame: 1'b0, line: 1'b0};

    typedef struct packed {
        display_sync_t            sync;
        logic [color_width-1:0]   color;
    } display_out_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [fb_addr_width-1:0] adr;
        logic [color_width-1:0]   dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [color_width-1:0]   dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic                     en;
        logic                     we;
        logic [fb_addr_width-1:0] addr;
        logic [color_width-1:0]   wdata;
    } fb_port_t;

endpackage

/* source/display_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480p60 timing generator. Registered sync and control bits
// with matching signed screen position, negative in blanking.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module display_timing import display_pkg::*; (
    input  logic                          clk_pix,
    input  logic                          rst_pix,
    output display_sync_t                 sync,
    output logic signed [coord_width-1:0] sx,  // lines up with sync
    output logic signed [coord_width-1:0] sy
);

    logic signed [coord_width-1:0] x;  // raw counter position
    logic signed [coord_width-1:0] y;
    logic                          in_hs;  // inside hsync pulse
    logic                          in_vs;

    assign in_hs = (x >= hs_sta) && (x < hs_end);
    assign in_vs = (y >= vs_sta) && (y < vs_end);

    // sync and control, one cycle behind x and y
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sync <= sync_idle;
        end else begin
            sync.hsync <= h_pol ? in_hs : ~in_hs;  // polarity from package
            sync.vsync <= v_pol ? in_vs : ~in_vs;
            sync.de    <= (x >= 0) && (y >= 0);
            sync.frame <= (x == h_sta) && (y == v_sta);
            sync.line  <= (x == h_sta);
        end
    end

    // position counters, start in top left of blanking
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            x <= coord_width'(h_sta);
            y <= coord_width'(v_sta);
        end else if (x == ha_end) begin  // end of line
            x <= coord_width'(h_sta);
            if (y == va_end) begin  // end of frame
                y <= coord_width'(v_sta);
            end else begin
                y <= y + 1'b1;
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    // one register stage so position matches sync
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sx <= coord_width'(h_sta);
            sy <= coord_width'(v_sta);
        end else begin
            sx <= x;
            sy <= y;
        end
    end

endmodule

/* source/display_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Framebuffer display top. Video out trails timing by 3 cycles;
// host writes and reads pixels over a Wishbone classic slave.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module display_top import display_pkg::*; (
    input  logic         clk_pix,
    input  logic         rst_pix,
    input  wb_req_t      wb_req,
    output wb_rsp_t      wb_rsp,
    output display_out_t video
);

    display_sync_t                 timing_sync;
    logic signed [coord_width-1:0] sx;
    logic signed [coord_width-1:0] sy;
    logic                          scan_req;
    logic [fb_addr_width-1:0]      scan_addr;
    logic [color_width-1:0]        scan_data;
    fb_port_t                      mem_port;
    logic [color_width-1:0]        mem_rdata;

    display_timing u_display_timing (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .sync    (timing_sync),
        .sx      (sx),
        .sy      (sy)
    );

    scanout u_scanout (
        .clk_pix   (clk_pix),
        .rst_pix   (rst_pix),
        .sync_in   (timing_sync),
        .sx        (sx),
        .sy        (sy),
        .scan_req  (scan_req),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .video     (video)
    );

    fb_arbiter u_fb_arbiter (
        .clk_pix   (clk_pix),
        .rst_pix   (rst_pix),
        .scan_req  (scan_req),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .mem       (mem_port),
        .mem_rdata (mem_rdata)
    );

    fb_ram u_fb_ram (
        .clk_pix (clk_pix),
        .port    (mem_port),
        .rdata   (mem_rdata)
    );

endmodule

/* source/fb_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shares the framebuffer port. Scanout reads always win; the
// Wishbone host is served in free cycles and waits on ack.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fb_arbiter import display_pkg::*; (
    input  logic                     clk_pix,
    input  logic                     rst_pix,
    input  logic                     scan_req,
    input  logic [fb_addr_width-1:0] scan_addr,
    output logic [color_width-1:0]   scan_data,
    input  wb_req_t                  wb_req,
    output wb_rsp_t                  wb_rsp,
    output fb_port_t                 mem,
    input  logic [color_width-1:0]   mem_rdata
);

    logic host_issue;  // host access goes to memory this cycle
    logic ack_q;       // host access issued last cycle
    logic scan_q;      // scanout owned memory last cycle

    // host only gets the port when scanout is idle and no ack is out
    assign host_issue = wb_req.cyc && wb_req.stb && !scan_req && !ack_q;

    always_comb begin
        mem.en    = scan_req || host_issue;
        mem.we    = host_issue && wb_req.we;  // scanout never writes
        mem.addr  = scan_req ? scan_addr : wb_req.adr;
        mem.wdata = wb_req.dat_w;
    end

    // track which side the returning word belongs to
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            ack_q  <= 1'b0;
            scan_q <= 1'b0;
        end else begin
            ack_q  <= host_issue;  // single cycle, stb still high blocks reissue
            scan_q <= scan_req;
        end
    end

    // steer memory data to its owner
    assign scan_data    = scan_q ? mem_rdata : '0;
    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = ack_q ? mem_rdata : '0;  // read data with ack

endmodule

/* source/fb_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port framebuffer, 160x120 colour words, sync read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fb_ram import display_pkg::*; (
    input  logic                   clk_pix,
    input  fb_port_t               port,
    output logic [color_width-1:0] rdata  // valid the cycle after en
);

    logic [color_width-1:0] mem [fb_depth];  // contents survive reset

    always_ff @(posedge clk_pix) begin
        if (port.en) begin
            if (port.we) begin
                mem[port.addr] <= port.wdata;
            end
            rdata <= mem[port.addr];  // old word on a write cycle
        end
    end

endmodule

/* source/scanout.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Turns screen position into framebuffer reads at 4x scale and
// delays sync by 3 cycles to line up with the colour.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scanout import display_pkg::*; (
    input  logic                          clk_pix,
    input  logic                          rst_pix,
    input  display_sync_t                 sync_in,
    input  logic signed [coord_width-1:0] sx,
    input  logic signed [coord_width-1:0] sy,
    output logic                          scan_req,
    output logic [fb_addr_width-1:0]      scan_addr,
    input  logic [color_width-1:0]        scan_data,  // arrives at t+2
    output display_out_t                  video
);

    logic                     active;     // visible pixel at t
    logic [coord_width-1:0]   row;        // framebuffer row
    logic [coord_width-1:0]   col;        // framebuffer column
    logic [fb_addr_width-1:0] addr_next;
    display_sync_t            sync_d [3];  // t+1, t+2, t+3
    logic [color_width-1:0]   color_q;

    assign active = (sx >= 0) && (sy >= 0);
    assign row    = coord_width'(sy >>> fb_scale_shift);  // /4 for 4x scale
    assign col    = coord_width'(sx >>> fb_scale_shift);
    assign addr_next = fb_addr_width'(row[fb_addr_width-1:0] * fb_width
                                      + col[fb_addr_width-1:0]);

    // read request, valid at t+1
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            scan_req <= 1'b0;
        end else begin
            scan_req <= active;
        end
        scan_addr <= addr_next;  // don't care when no request
    end

    // sync delay line, idle values in reset
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sync_d[0] <= sync_idle;
            sync_d[1] <= sync_idle;
            sync_d[2] <= sync_idle;
        end else begin
            sync_d[0] <= sync_in;
            sync_d[1] <= sync_d[0];
            sync_d[2] <= sync_d[1];
        end
    end

    // colour lands with sync_d[2], blanked outside de
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            color_q <= '0;
        end else begin
            color_q <= sync_d[1].de ? scan_data : '0;
        end
    end

    assign video.sync  = sync_d[2];
    assign video.color = color_q;

endmodule
